/* dv/track_tb_model.svh */
/*
 * Reference model of the registers, track slots and association rule.
 * Included inside the testbench module and shares its scope.
 */

`ifndef TRACK_TB_MODEL_SVH
`define TRACK_TB_MODEL_SVH

// Mirrored configuration and slot contents
track_pkg::cfg_t  m_cfg;
track_pkg::bbox_t m_box [track_pkg::NUM_SLOTS];
int               m_age [track_pkg::NUM_SLOTS];

// Everything dead after reset
function automatic void model_reset();
	m_cfg = '0;
	for (int i = 0; i < track_pkg::NUM_SLOTS; i++)
	begin
		m_box[i] = '0;
		m_age[i] = 7;
	end
endfunction

// Unmapped writes are dropped
function automatic void model_reg_write(input logic [7:0] addr, input logic [31:0] data);
	case (addr)
		track_pkg::ADDR_W_POS:          m_cfg.w_pos = data[7:0];
		track_pkg::ADDR_W_WIDTH:        m_cfg.w_width = data[7:0];
		track_pkg::ADDR_W_HEIGHT:       m_cfg.w_height = data[7:0];
		track_pkg::ADDR_W_COLOR1:       m_cfg.w_color1 = data[7:0];
		track_pkg::ADDR_W_COLOR2:       m_cfg.w_color2 = data[7:0];
		track_pkg::ADDR_W_HISTORY:      m_cfg.w_history = data[7:0];
		track_pkg::ADDR_HISTORY_FRAMES: m_cfg.history_frames = data[2:0];
		track_pkg::ADDR_NEW_TRACK_TH:   m_cfg.new_track_th = data[19:0];
		default:                        m_cfg = m_cfg;
	endcase
endfunction

function automatic logic [31:0] model_reg_read(input logic [7:0] addr);
	case (addr)
		track_pkg::ADDR_W_POS:          return {24'd0, m_cfg.w_pos};
		track_pkg::ADDR_W_WIDTH:        return {24'd0, m_cfg.w_width};
		track_pkg::ADDR_W_HEIGHT:       return {24'd0, m_cfg.w_height};
		track_pkg::ADDR_W_COLOR1:       return {24'd0, m_cfg.w_color1};
		track_pkg::ADDR_W_COLOR2:       return {24'd0, m_cfg.w_color2};
		track_pkg::ADDR_W_HISTORY:      return {24'd0, m_cfg.w_history};
		track_pkg::ADDR_HISTORY_FRAMES: return {29'd0, m_cfg.history_frames};
		track_pkg::ADDR_NEW_TRACK_TH:   return {12'd0, m_cfg.new_track_th};
		default:                        return 32'd0;
	endcase
endfunction

// One frame tick, ages stop at 7
function automatic void model_frame();
	for (int i = 0; i < track_pkg::NUM_SLOTS; i++)
	begin
		if (m_age[i] < 7)
			m_age[i] = m_age[i] + 1;
	end
endfunction

function automatic int feature_gap(input int a, input int b);
	return (a > b) ? (a - b) : (b - a);
endfunction

// Weighted distance of a detection to one stored slot
function automatic int model_cost(input track_pkg::bbox_t d, input int idx);
	track_pkg::bbox_t s;
	int sum;
	s = m_box[idx];
	sum = m_cfg.w_pos * (feature_gap(d.x, s.x) + feature_gap(d.y, s.y));
	sum = sum + m_cfg.w_width * feature_gap(d.w, s.w);
	sum = sum + m_cfg.w_height * feature_gap(d.h, s.h);
	sum = sum + m_cfg.w_color1 * feature_gap(d.color1, s.color1);
	sum = sum + m_cfg.w_color2 * feature_gap(d.color2, s.color2);
	sum = sum + m_cfg.w_history * m_age[idx];
	return sum;
endfunction

// Match or new track, then the slot write
function automatic track_pkg::result_t model_associate(input track_pkg::bbox_t d);
	track_pkg::result_t r;
	int best_cost;
	int best_idx;
	int dead_idx;
	int old_idx;
	int c;
	int tgt;
	best_cost = 0;
	best_idx = -1;
	dead_idx = -1;
	old_idx = 0;
	for (int i = 0; i < track_pkg::NUM_SLOTS; i++)
	begin
		if (m_age[i] < m_cfg.history_frames)
		begin
			c = model_cost(d, i);
			// Lower index kept on ties
			if ((best_idx < 0) || (c < best_cost))
			begin
				best_cost = c;
				best_idx = i;
			end
		end
		else if (dead_idx < 0)
			dead_idx = i;
		if (m_age[i] > m_age[old_idx])
			old_idx = i;
	end
	r.is_new = 1'b1;
	if ((best_idx >= 0) && (best_cost <= m_cfg.new_track_th))
	begin
		tgt = best_idx;
		r.is_new = 1'b0;
	end
	else if (dead_idx >= 0)
		tgt = dead_idx;
	else
		tgt = old_idx;
	r.track_id = 3'(tgt);
	r.cost = (best_idx >= 0) ? 20'(best_cost) : {track_pkg::COST_W{1'b1}};
	m_box[tgt] = d;
	m_age[tgt] = 0;
	return r;
endfunction

`endif

/* dv/track_tb.sv */
/*
 * Testbench of track_top with random stimulus from seed 5 checked against a model.
 * Inputs change and outputs are sampled on the falling edge.
 * Stops at the first mismatch or timeout.
 */

`default_nettype none

module track_tb;

	logic                         clk;
	logic                         reset_N;
	logic                         psel;
	logic                         penable;
	logic                         pwrite;
	logic [track_pkg::ADDR_W-1:0] paddr;
	logic [31:0]                  pwdata;
	logic [31:0]                  prdata;
	logic                         pready;
	logic                         frame_start;
	logic                         det_valid;
	track_pkg::bbox_t             det;
	logic                         det_ready;
	logic                         res_valid;
	track_pkg::result_t           res;
	int                           seed;

	`include "track_tb_model.svh"

	track_top DUT (
		.clk         (clk),
		.reset_N     (reset_N),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.frame_start (frame_start),
		.det_valid   (det_valid),
		.det         (det),
		.det_ready   (det_ready),
		.res_valid   (res_valid),
		.res         (res)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic track_pkg::bbox_t random_box();
		logic [63:0] bits;
		bits = {next_random(), next_random()};
		return bits[47:0];
	endfunction

	// Box spread out along x with the rest fixed
	function automatic track_pkg::bbox_t spaced_box(input int x);
		track_pkg::bbox_t b;
		b.x = 8'(x);
		b.y = 8'd50;
		b.w = 8'd20;
		b.h = 8'd30;
		b.color1 = 8'd100;
		b.color2 = 8'd200;
		return b;
	endfunction

	function automatic logic [track_pkg::ADDR_W-1:0] reg_addr(input int idx);
		case (idx)
			0:       return track_pkg::ADDR_W_POS;
			1:       return track_pkg::ADDR_W_WIDTH;
			2:       return track_pkg::ADDR_W_HEIGHT;
			3:       return track_pkg::ADDR_W_COLOR1;
			4:       return track_pkg::ADDR_W_COLOR2;
			5:       return track_pkg::ADDR_W_HISTORY;
			6:       return track_pkg::ADDR_HISTORY_FRAMES;
			default: return track_pkg::ADDR_NEW_TRACK_TH;
		endcase
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected)
			stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, actual, expected));
	endtask

	// --------------------
	// APB
	// --------------------
	// Setup then access phase on successive falling edges
	task automatic apb_access(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		check("pready", pready, 0);
		check("prdata", prdata, 0);
		penable = 1'b1;
		@(negedge clk);
		check("pready", pready, 1);
		// Read data only on a read
		if (write)
			check("prdata", prdata, 0);
		rdata = prdata;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused);
		model_reg_write(addr, data);
	endtask

	task automatic reg_check(input logic [7:0] addr);
		logic [31:0] rdata;
		apb_access(1'b0, addr, 32'd0, rdata);
		check("prdata", rdata, model_reg_read(addr));
	endtask

	// --------------------
	// Tracker side
	// --------------------
	// Mode 0 no frames, 1 random frames, 2 a frame every cycle
	task automatic idle_cycles(input int n, input int mode);
		logic pulse;
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			check("res_valid", res_valid, 0);
			check("pready", pready, 0);
			pulse = (mode == 2) || ((mode == 1) && ((next_random() & 32'h1) != 0));
			frame_start = pulse;
			if (pulse)
				model_frame();
		end
		@(negedge clk);
		frame_start = 1'b0;
	endtask

	// One detection with optional dropped strobes while busy
	task automatic send_detection(input track_pkg::bbox_t box, input logic junk,
			output track_pkg::result_t got);
		int cycles;
		track_pkg::result_t exp_res;
		@(negedge clk);
		check("det_ready", det_ready, 1);
		det_valid = 1'b1;
		det = box;
		exp_res = model_associate(box);
		// Counted from the accepting rising edge
		@(negedge clk);
		cycles = 0;
		while (res_valid !== 1'b1)
		begin
			if (cycles > 4 * track_pkg::LATENCY)
				stop_on_error("Timed out waiting for res_valid after a detection");
			check("det_ready", det_ready, 0);
			det_valid = junk && ((next_random() & 32'h1) != 0);
			det = random_box();
			@(negedge clk);
			cycles++;
		end
		det_valid = 1'b0;
		check("latency", cycles, track_pkg::LATENCY);
		check("det_ready", det_ready, 1);
		check("res.track_id", res.track_id, exp_res.track_id);
		check("res.is_new", res.is_new, exp_res.is_new);
		check("res.cost", res.cost, exp_res.cost);
		got = res;
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial
	begin
		track_pkg::result_t r;
		track_pkg::bbox_t   box;
		logic [7:0]         addr;
		int                 exp_cost;
		seed = 5;
		reset_N = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		frame_start = 1'b0;
		det_valid = 1'b0;
		det = '0;
		model_reset();
		repeat (5) @(negedge clk);
		reset_N = 1'b1;
		@(negedge clk);
		check("det_ready", det_ready, 1);
		check("res_valid", res_valid, 0);
		check("pready", pready, 0);

		// Reset values, masked readback, unmapped space
		for (int i = 0; i < 8; i++)
			reg_check(reg_addr(i));
		for (int i = 0; i < 8; i++)
		begin
			reg_write(reg_addr(i), next_random());
			reg_check(reg_addr(i));
		end
		for (int i = 0; i < 4; i++)
		begin
			addr = 8'h20 + 8'(next_random() % 224);
			reg_write(addr, next_random());
			reg_check(addr);
		end
		reg_check(8'h01);
		for (int i = 0; i < 8; i++)
			reg_check(reg_addr(i));

		// Depth 0 leaves nothing live
		reg_write(track_pkg::ADDR_HISTORY_FRAMES, 32'd0);
		for (int i = 0; i < 4; i++)
		begin
			send_detection(random_box(), 1'b0, r);
			check("res.is_new", r.is_new, 1);
			check("res.track_id", r.track_id, 0);
			check("res.cost", r.cost, 20'hFFFFF);
		end

		// Fill slots in order and then reuse the oldest
		for (int i = 0; i < 6; i++)
			reg_write(reg_addr(i), 32'd1);
		reg_write(track_pkg::ADDR_NEW_TRACK_TH, 32'd0);
		reg_write(track_pkg::ADDR_HISTORY_FRAMES, 32'd7);
		idle_cycles(7, 2);
		for (int i = 0; i < 8; i++)
		begin
			send_detection(spaced_box(i * 20 + 5), 1'b0, r);
			check("res.track_id", r.track_id, i);
			check("res.is_new", r.is_new, 1);
		end
		for (int i = 0; i < 4; i++)
		begin
			idle_cycles(3, 1);
			send_detection(random_box(), 1'b1, r);
		end

		// Random configuration, frames and boxes
		for (int i = 0; i < 8; i++)
			reg_write(reg_addr(i), next_random());
		for (int n = 0; n < 300; n++)
		begin
			if ((next_random() % 16) == 0)
				reg_write(reg_addr(next_random() % 8), next_random() >> (next_random() % 24));
			idle_cycles(next_random() % 3, 1);
			if ((next_random() & 32'h1) != 0)
				box = random_box();
			else
			begin
				// Near copy of a stored box
				box = m_box[next_random() % 8];
				box.x = box.x + 8'(next_random() % 4);
			end
			send_detection(box, 1'b1, r);
		end

		// Identical box finds its own slot under an open threshold
		reg_write(track_pkg::ADDR_W_POS, 32'd2);
		for (int i = 1; i < 5; i++)
			reg_write(reg_addr(i), 32'd1);
		reg_write(track_pkg::ADDR_W_HISTORY, 32'd3);
		reg_write(track_pkg::ADDR_NEW_TRACK_TH, 32'd0);
		reg_write(track_pkg::ADDR_HISTORY_FRAMES, 32'd7);
		idle_cycles(7, 2);
		for (int i = 0; i < 4; i++)
		begin
			send_detection(spaced_box(i * 40 + 10), 1'b0, r);
			check("res.track_id", r.track_id, i);
			idle_cycles(1, 2);
		end
		reg_write(track_pkg::ADDR_NEW_TRACK_TH, 32'hFFFFF);
		exp_cost = 3 * m_age[1];
		send_detection(spaced_box(50), 1'b0, r);
		check("res.track_id", r.track_id, 1);
		check("res.is_new", r.is_new, 0);
		check("res.cost", r.cost, exp_cost);
		exp_cost = 3 * m_age[3];
		send_detection(spaced_box(130), 1'b0, r);
		check("res.track_id", r.track_id, 3);
		check("res.is_new", r.is_new, 0);
		check("res.cost", r.cost, exp_cost);

		// No stray results afterwards
		idle_cycles(2 * track_pkg::LATENCY, 0);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+dv
source/track_pkg.sv
source/track_reg_file.sv
source/track_history_buf.sv
source/track_cost_unit.sv
source/track_ctrl.sv
source/track_top.sv
dv/track_tb.sv

/* source/track_cost_unit.sv */
/*
 * Two-stage weighted distance between a detection and a stored slot.
 * Position term uses |dx| + |dy| in place of an overlap measure.
 * Fully pipelined, one item may enter every cycle.
 */

`default_nettype none

module track_cost_unit (
	input  logic                         clk,
	input  logic                         reset_N,
	input  logic                         in_valid,
	input  track_pkg::bbox_t             in_det,
	input  track_pkg::slot_t             in_slot,
	input  track_pkg::cfg_t              cfg,
	output logic                         out_valid,
	output logic [track_pkg::COST_W-1:0] out_cost
);

	// Stage one feature distances
	logic                          s1_valid;
	logic [track_pkg::FEAT_W:0]    s1_dpos;
	logic [track_pkg::FEAT_W-1:0]  s1_dw;
	logic [track_pkg::FEAT_W-1:0]  s1_dh;
	logic [track_pkg::FEAT_W-1:0]  s1_dc1;
	logic [track_pkg::FEAT_W-1:0]  s1_dc2;
	logic [track_pkg::AGE_W-1:0]   s1_age;

	function automatic logic [track_pkg::FEAT_W-1:0] abs_diff(
		input logic [track_pkg::FEAT_W-1:0] a,
		input logic [track_pkg::FEAT_W-1:0] b
	);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// --------------------
	// Valid pipe
	// --------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
		end
	end

	// --------------------
	// Data pipe
	// --------------------
	always_ff @(posedge clk)
	begin
		// Stage one, absolute differences and age
		s1_dpos <= abs_diff(in_det.x, in_slot.box.x) + abs_diff(in_det.y, in_slot.box.y);
		s1_dw   <= abs_diff(in_det.w, in_slot.box.w);
		s1_dh   <= abs_diff(in_det.h, in_slot.box.h);
		s1_dc1  <= abs_diff(in_det.color1, in_slot.box.color1);
		s1_dc2  <= abs_diff(in_det.color2, in_slot.box.color2);
		s1_age  <= in_slot.age;

		// Stage two, weighted sum sized to the cost width
		out_cost <= cfg.w_pos * s1_dpos
			+ cfg.w_width * s1_dw
			+ cfg.w_height * s1_dh
			+ cfg.w_color1 * s1_dc1
			+ cfg.w_color2 * s1_dc2
			+ cfg.w_history * s1_age;
	end

endmodule

`default_nettype wire

/* source/track_ctrl.sv */
/*
 * Scan, minimum search and match or new-track decision for one detection.
 * Accepts a detection only when det_ready is high, result after LATENCY cycles.
 * Ages must not change during a scan, frame_start belongs in idle time.
 */

`default_nettype none

module track_ctrl (
	input  logic                         clk,
	input  logic                         reset_N,
	input  logic                         det_valid,
	input  track_pkg::bbox_t             det,
	output logic                         det_ready,
	input  track_pkg::cfg_t              cfg,
	output logic [track_pkg::SLOT_W-1:0] rd_idx,
	input  track_pkg::slot_t             rd_slot,
	output logic                         cu_valid,
	output track_pkg::bbox_t             cu_det,
	output track_pkg::slot_t             cu_slot,
	input  logic                         cost_valid,
	input  logic [track_pkg::COST_W-1:0] cost,
	output logic                         wr_en,
	output logic [track_pkg::SLOT_W-1:0] wr_idx,
	output track_pkg::bbox_t             wr_box,
	output logic                         res_valid,
	output track_pkg::result_t           res
);

	typedef enum logic [1:0] {ST_IDLE, ST_SCAN, ST_DRAIN} state_t;

	// Slot facts that ride beside the cost pipe
	typedef struct packed {
		logic                        live;
		logic [track_pkg::AGE_W-1:0] age;
	} tag_t;

	state_t                       state;
	logic [track_pkg::SLOT_W-1:0] issue_idx;
	logic [track_pkg::SLOT_W-1:0] rcv_idx;
	logic                         decide_q;
	track_pkg::bbox_t             det_q;
	tag_t                         tag_d1;
	tag_t                         tag_d2;
	logic                         best_valid;
	logic [track_pkg::COST_W-1:0] best_cost;
	logic [track_pkg::SLOT_W-1:0] best_idx;
	logic                         dead_found;
	logic [track_pkg::SLOT_W-1:0] dead_idx;
	logic [track_pkg::AGE_W-1:0]  old_age;
	logic [track_pkg::SLOT_W-1:0] old_idx;
	logic                         accept;
	logic                         last_cost;
	logic                         match;
	logic [track_pkg::SLOT_W-1:0] target;
	track_pkg::result_t           dec_res;

	assign accept    = det_valid && (state == ST_IDLE);
	assign last_cost = cost_valid && (rcv_idx == track_pkg::LAST_SLOT);

	// --------------------
	// FSM and issue count
	// --------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			state     <= ST_IDLE;
			issue_idx <= '0;
			decide_q  <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			res_valid <= decide_q;
			case (state)
				ST_IDLE:
					if (accept)
					begin
						state     <= ST_SCAN;
						issue_idx <= '0;
					end
				ST_SCAN:
				begin
					// One slot per cycle, wraps back to zero after the last
					issue_idx <= issue_idx + 1'b1;
					if (issue_idx == track_pkg::LAST_SLOT)
						state <= ST_DRAIN;
				end
				ST_DRAIN:
					if (decide_q)
					begin
						state    <= ST_IDLE;
						decide_q <= 1'b0;
					end
					else if (last_cost)
						decide_q <= 1'b1;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// --------------------
	// Running search
	// --------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			rcv_idx    <= '0;
			best_valid <= 1'b0;
			best_cost  <= '0;
			best_idx   <= '0;
			dead_found <= 1'b0;
			dead_idx   <= '0;
			old_age    <= '0;
			old_idx    <= '0;
		end
		else if (accept)
		begin
			rcv_idx    <= '0;
			best_valid <= 1'b0;
			dead_found <= 1'b0;
		end
		else if (cost_valid)
		begin
			rcv_idx <= rcv_idx + 1'b1;
			// Strict compares keep the lower index on ties
			if (tag_d2.live && (!best_valid || (cost < best_cost)))
			begin
				best_valid <= 1'b1;
				best_cost  <= cost;
				best_idx   <= rcv_idx;
			end
			if (!tag_d2.live && !dead_found)
			begin
				dead_found <= 1'b1;
				dead_idx   <= rcv_idx;
			end
			if ((rcv_idx == '0) || (tag_d2.age > old_age))
			begin
				old_age <= tag_d2.age;
				old_idx <= rcv_idx;
			end
		end
	end

	// Detection latch, tag delay and result payload
	always_ff @(posedge clk)
	begin
		if (accept)
			det_q <= det;
		tag_d1.live <= rd_slot.age < cfg.history_frames;
		tag_d1.age  <= rd_slot.age;
		tag_d2      <= tag_d1;
		if (decide_q)
			res <= dec_res;
	end

	// --------------------
	// Association decision
	// --------------------
	always_comb
	begin
		match = best_valid && (best_cost <= cfg.new_track_th);
		// New track goes to the first dead slot, else the oldest
		if (match)
			target = best_idx;
		else if (dead_found)
			target = dead_idx;
		else
			target = old_idx;
		dec_res.track_id = target;
		dec_res.is_new   = !match;
		dec_res.cost     = best_valid ? best_cost : '1;
	end

	assign det_ready = (state == ST_IDLE);
	assign rd_idx    = issue_idx;
	assign cu_valid  = (state == ST_SCAN);
	assign cu_det    = det_q;
	assign cu_slot   = rd_slot;
	// Write lands on the same edge that raises res_valid
	assign wr_en     = decide_q;
	assign wr_idx    = target;
	assign wr_box    = det_q;

endmodule

`default_nettype wire

/* source/track_history_buf.sv */
/*
 * Track slot store with one combinational read port and one write port.
 * Ages saturate at 7 and reset to 7, so every slot starts dead.
 * A write on a slot wins over aging of that slot in the same cycle.
 */

`default_nettype none

module track_history_buf (
	input  logic                         clk,
	input  logic                         reset_N,
	input  logic                         frame_start,
	input  logic [track_pkg::SLOT_W-1:0] rd_idx,
	output track_pkg::slot_t             rd_slot,
	input  logic                         wr_en,
	input  logic [track_pkg::SLOT_W-1:0] wr_idx,
	input  track_pkg::bbox_t             wr_box
);

	// Box payload and per-slot age
	track_pkg::bbox_t             box_mem [track_pkg::NUM_SLOTS];
	logic [track_pkg::AGE_W-1:0]  age_q   [track_pkg::NUM_SLOTS];

	// --------------------
	// Box storage
	// --------------------
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			box_mem[wr_idx] <= wr_box;
		end
	end

	// --------------------
	// Age counters
	// --------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			for (int i = 0; i < track_pkg::NUM_SLOTS; i++)
			begin
				age_q[i] <= track_pkg::AGE_MAX;
			end
		end
		else
		begin
			for (int i = 0; i < track_pkg::NUM_SLOTS; i++)
			begin
				// Fresh write restarts the age
				if (wr_en && (wr_idx == track_pkg::SLOT_W'(i)))
					age_q[i] <= '0;
				else if (frame_start && (age_q[i] != track_pkg::AGE_MAX))
					age_q[i] <= age_q[i] + 1'b1;
			end
		end
	end

	// Combinational read for the scan
	always_comb
	begin
		rd_slot.box = box_mem[rd_idx];
		rd_slot.age = age_q[rd_idx];
	end

endmodule

`default_nettype wire

/* source/track_pkg.sv */
/*
 * Shared widths, slot count, APB register map and structs of the track association block.
 * The cost width covers the largest weighted sum with 8-bit features and weights.
 */

`default_nettype none

package track_pkg;

	// --------------------
	// Widths and sizes
	// --------------------
	localparam int FEAT_W    = 8;
	localparam int WEIGHT_W  = 8;
	localparam int AGE_W     = 3;
	localparam int NUM_SLOTS = 8;
	localparam int SLOT_W    = 3;
	localparam int COST_W    = 20;
	localparam int ADDR_W    = 8;

	// Detection to result, one issue per slot plus pipe and decision
	localparam int LATENCY = NUM_SLOTS + 3;

	// Index of the last slot in a scan
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_SLOTS - 1);

	// Age counters stop here
	localparam logic [AGE_W-1:0] AGE_MAX = '1;

	// --------------------
	// APB register map
	// --------------------
	localparam logic [ADDR_W-1:0] ADDR_W_POS          = 8'h00;
	localparam logic [ADDR_W-1:0] ADDR_W_WIDTH        = 8'h04;
	localparam logic [ADDR_W-1:0] ADDR_W_HEIGHT       = 8'h08;
	localparam logic [ADDR_W-1:0] ADDR_W_COLOR1       = 8'h0C;
	localparam logic [ADDR_W-1:0] ADDR_W_COLOR2       = 8'h10;
	localparam logic [ADDR_W-1:0] ADDR_W_HISTORY      = 8'h14;
	localparam logic [ADDR_W-1:0] ADDR_HISTORY_FRAMES = 8'h18;
	localparam logic [ADDR_W-1:0] ADDR_NEW_TRACK_TH   = 8'h1C;

	// --------------------
	// Structs
	// --------------------
	// One detection or stored track box, 48 bits
	typedef struct packed {
		logic [FEAT_W-1:0] x;
		logic [FEAT_W-1:0] y;
		logic [FEAT_W-1:0] w;
		logic [FEAT_W-1:0] h;
		logic [FEAT_W-1:0] color1;
		logic [FEAT_W-1:0] color2;
	} bbox_t;

	// Host configuration, 71 bits
	typedef struct packed {
		logic [WEIGHT_W-1:0] w_pos;
		logic [WEIGHT_W-1:0] w_width;
		logic [WEIGHT_W-1:0] w_height;
		logic [WEIGHT_W-1:0] w_color1;
		logic [WEIGHT_W-1:0] w_color2;
		logic [WEIGHT_W-1:0] w_history;
		logic [AGE_W-1:0]    history_frames;
		logic [COST_W-1:0]   new_track_th;
	} cfg_t;

	// Stored track with frames since its last update, 51 bits
	typedef struct packed {
		bbox_t            box;
		logic [AGE_W-1:0] age;
	} slot_t;

	// Association outcome, 24 bits
	typedef struct packed {
		logic [SLOT_W-1:0] track_id;
		logic              is_new;
		logic [COST_W-1:0] cost;
	} result_t;

endpackage

`default_nettype wire

/* source/track_reg_file.sv */
/*
 * APB configuration registers, no wait states and no pslverr.
 * Each register keeps only the low pwdata bits of its width.
 * Unmapped addresses read as zero and drop writes.
 */

`default_nettype none

module track_reg_file (
	input  logic                         clk,
	input  logic                         reset_N,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [track_pkg::ADDR_W-1:0] paddr,
	input  logic [31:0]                  pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output track_pkg::cfg_t              cfg
);

	// --------------------
	// Access decode
	// --------------------
	logic            access;
	logic            wr_access;
	logic            rd_access;
	track_pkg::cfg_t cfg_q;

	// Access phase of a transfer, answered right away
	assign access    = psel && penable;
	assign wr_access = access && pwrite;
	assign rd_access = access && !pwrite;
	assign pready    = access;

	assign cfg = cfg_q;

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			cfg_q <= '0;
		end
		else if (wr_access)
		begin
			case (paddr)
				track_pkg::ADDR_W_POS:
					cfg_q.w_pos <= pwdata[track_pkg::WEIGHT_W-1:0];
				track_pkg::ADDR_W_WIDTH:
					cfg_q.w_width <= pwdata[track_pkg::WEIGHT_W-1:0];
				track_pkg::ADDR_W_HEIGHT:
					cfg_q.w_height <= pwdata[track_pkg::WEIGHT_W-1:0];
				track_pkg::ADDR_W_COLOR1:
					cfg_q.w_color1 <= pwdata[track_pkg::WEIGHT_W-1:0];
				track_pkg::ADDR_W_COLOR2:
					cfg_q.w_color2 <= pwdata[track_pkg::WEIGHT_W-1:0];
				track_pkg::ADDR_W_HISTORY:
					cfg_q.w_history <= pwdata[track_pkg::WEIGHT_W-1:0];
				track_pkg::ADDR_HISTORY_FRAMES:
					cfg_q.history_frames <= pwdata[track_pkg::AGE_W-1:0];
				track_pkg::ADDR_NEW_TRACK_TH:
					cfg_q.new_track_th <= pwdata[track_pkg::COST_W-1:0];
				default:
					cfg_q <= cfg_q;
			endcase
		end
	end

	// --------------------
	// Register reads
	// --------------------
	// Zero outside a read access, fields zero-extended to 32 bits
	always_comb
	begin
		prdata = '0;
		if (rd_access)
		begin
			case (paddr)
				track_pkg::ADDR_W_POS:          prdata = 32'(cfg_q.w_pos);
				track_pkg::ADDR_W_WIDTH:        prdata = 32'(cfg_q.w_width);
				track_pkg::ADDR_W_HEIGHT:       prdata = 32'(cfg_q.w_height);
				track_pkg::ADDR_W_COLOR1:       prdata = 32'(cfg_q.w_color1);
				track_pkg::ADDR_W_COLOR2:       prdata = 32'(cfg_q.w_color2);
				track_pkg::ADDR_W_HISTORY:      prdata = 32'(cfg_q.w_history);
				track_pkg::ADDR_HISTORY_FRAMES: prdata = 32'(cfg_q.history_frames);
				track_pkg::ADDR_NEW_TRACK_TH:   prdata = 32'(cfg_q.new_track_th);
				default:                        prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/track_top.sv */
/*
 * Detection to track association top, APB configured.
 * No back-pressure on results, det_valid is dropped while det_ready is low.
 */

`default_nettype none

module track_top (
	input  logic                         clk,
	input  logic                         reset_N,
	// APB
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [track_pkg::ADDR_W-1:0] paddr,
	input  logic [31:0]                  pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	// Tracker side
	input  logic                         frame_start,
	input  logic                         det_valid,
	input  track_pkg::bbox_t             det,
	output logic                         det_ready,
	output logic                         res_valid,
	output track_pkg::result_t           res
);

	track_pkg::cfg_t              cfg;
	logic [track_pkg::SLOT_W-1:0] rd_idx;
	track_pkg::slot_t             rd_slot;
	logic                         cu_valid;
	track_pkg::bbox_t             cu_det;
	track_pkg::slot_t             cu_slot;
	logic                         cost_valid;
	logic [track_pkg::COST_W-1:0] cost;
	logic                         wr_en;
	logic [track_pkg::SLOT_W-1:0] wr_idx;
	track_pkg::bbox_t             wr_box;

	// --------------------
	// Configuration
	// --------------------
	track_reg_file u_reg_file (
		.clk     (clk),
		.reset_N (reset_N),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.cfg     (cfg)
	);

	// Track slot store
	track_history_buf u_history_buf (
		.clk         (clk),
		.reset_N     (reset_N),
		.frame_start (frame_start),
		.rd_idx      (rd_idx),
		.rd_slot     (rd_slot),
		.wr_en       (wr_en),
		.wr_idx      (wr_idx),
		.wr_box      (wr_box)
	);

	// Two-cycle cost pipe
	track_cost_unit u_cost_unit (
		.clk       (clk),
		.reset_N   (reset_N),
		.in_valid  (cu_valid),
		.in_det    (cu_det),
		.in_slot   (cu_slot),
		.cfg       (cfg),
		.out_valid (cost_valid),
		.out_cost  (cost)
	);

	// Scan and decision
	track_ctrl u_ctrl (
		.clk        (clk),
		.reset_N    (reset_N),
		.det_valid  (det_valid),
		.det        (det),
		.det_ready  (det_ready),
		.cfg        (cfg),
		.rd_idx     (rd_idx),
		.rd_slot    (rd_slot),
		.cu_valid   (cu_valid),
		.cu_det     (cu_det),
		.cu_slot    (cu_slot),
		.cost_valid (cost_valid),
		.cost       (cost),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_box     (wr_box),
		.res_valid  (res_valid),
		.res        (res)
	);

endmodule

`default_nettype wire
